/* hdl/trace_format_pkg.sv */
package trace_format_pkg;

    // width of one word from the upstream FIFO
    localparam int word_width = 64;

    // units are packed back to back on this granularity
    localparam int align_width = 8;

    // largest logging unit, also the width of one assembled output word
    localparam int unit_width = 256;

    // length field at the bottom of every unit, counted in bits
    localparam int offset_width = 9;

    // alignment slots in one input word
    localparam int word_slots = word_width / align_width;

    // index of a slot inside one word
    localparam int slot_off_width = $clog2(word_slots);

    // unit length counted in slots, needs room for the full 256/8 = 32
    localparam int len_slots_width = $clog2(unit_width / align_width + 1);

    // input words needed to fill one output unit
    localparam int unit_words = unit_width / word_width;

    // one 64-bit segment seen two ways
    // raw is plain body data, hdr is the first segment of a unit
    typedef union packed {
        logic [word_width-1:0] raw;
        struct packed {
            logic [word_width-offset_width-1:0] payload;
            logic [offset_width-1:0]            len;
        } hdr;
    } trace_word_u;

endpackage

/* hdl/parser_ctrl_pkg.sv */
package parser_ctrl_pkg;

    // high half of the shift buffer
    // hi_full means a word sits there waiting to move down
    typedef enum logic [0:0] {
        hi_empty,
        hi_full
    } hi_state_e;

    // low half of the shift buffer
    // header: the current slot offset points at the start of a unit
    // body: the current slot offset continues a unit from the last word
    typedef enum logic [1:0] {
        lo_empty,
        lo_header,
        lo_body
    } lo_state_e;

    // unit assembly
    typedef enum logic [1:0] {
        asm_wait_header,
        asm_wait_body,
        asm_done
    } asm_state_e;

endpackage

/* hdl/replay_shift_buffer.sv */
`timescale 1ns/1ps

module replay_shift_buffer (
    input  logic                                    clk,
    input  logic                                    sync_rst_n,
    input  logic [trace_format_pkg::word_width-1:0] in_data,
    input  logic                                    in_empty,
    input  logic                                    out_almfull,
    output logic                                    in_rd_en,
    output logic                                    seg_valid,
    output trace_format_pkg::trace_word_u           seg_data,
    output logic [trace_format_pkg::offset_width-1:0] seg_len
);
    import trace_format_pkg::*;
    import parser_ctrl_pkg::*;

    hi_state_e hi_state;
    hi_state_e hi_state_next;
    lo_state_e lo_state;
    lo_state_e lo_state_next;

    // two words, slot view; upper word is the high half
    logic [2*word_slots-1:0][align_width-1:0] shift_buf;

    logic                       hi_is_full;
    logic                       lo_is_empty;
    logic                       hi_lo_shift;
    logic                       lo_out;
    logic                       lo_pad;
    logic                       lo_exhaust;
    logic                       lo_satisfied;
    logic [slot_off_width-1:0]  lo_off;
    logic [len_slots_width-1:0] lo_remain;
    logic [len_slots_width-1:0] lo_remain_reg;
    trace_word_u                lo_seg;

    assign hi_is_full  = (hi_state == hi_full);
    assign lo_is_empty = (lo_state == lo_empty);

    // one word taken from the current slot, may reach into the high half
    assign lo_seg.raw = shift_buf[lo_off +: word_slots];

    // remaining unit length in slots
    // header decodes it from the segment, body keeps it in a register
    always_comb begin
        case (lo_state)
            lo_header: lo_remain = lo_seg.hdr.len[offset_width-1 -: len_slots_width];
            lo_body:   lo_remain = lo_remain_reg;
            default:   lo_remain = '0;
        endcase
    end

    // zero length header means the stream ended inside this word
    // the rest of the low half is padding and gets dropped
    assign lo_pad = (lo_state == lo_header) && (lo_remain == '0);

    // only emit when high half is loaded so a segment never runs past valid data
    assign lo_out = hi_is_full && !lo_is_empty;

    // segment uses up everything left in the low half
    assign lo_exhaust = lo_pad ||
        ((lo_remain + len_slots_width'(lo_off)) >= len_slots_width'(word_slots));

    // unit tail fits in this segment
    assign lo_satisfied = (lo_remain <= len_slots_width'(word_slots));

    assign hi_lo_shift = hi_is_full && (lo_is_empty || (lo_out && lo_exhaust));

    // read when the high half is free now or frees up this cycle
    assign in_rd_en = !in_empty && !out_almfull && (!hi_is_full || hi_lo_shift);

    always_comb begin
        case (hi_state)
            hi_empty: hi_state_next = in_rd_en ? hi_full : hi_empty;
            // shift with a new read is a flow and stays full
            hi_full:  hi_state_next = (hi_lo_shift && !in_rd_en) ? hi_empty : hi_full;
            default:  hi_state_next = hi_empty;
        endcase
    end

    always_comb begin
        case (lo_state)
            lo_empty: lo_state_next = hi_lo_shift ? lo_header : lo_empty;
            lo_header, lo_body: begin
                if (hi_lo_shift) begin
                    // tail ends in the new low word or the unit still goes on
                    lo_state_next = lo_satisfied ? lo_header : lo_body;
                end else if (lo_out) begin
                    // unit ended inside the low half, next one starts there
                    lo_state_next = lo_header;
                end else begin
                    lo_state_next = lo_state;
                end
            end
            default: lo_state_next = lo_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= hi_empty;
            lo_state <= lo_empty;
            lo_off   <= '0;
        end else begin
            hi_state <= hi_state_next;
            lo_state <= lo_state_next;
            if (lo_is_empty || (lo_pad && hi_lo_shift)) begin
                lo_off <= '0;
            end else if ((hi_lo_shift && lo_satisfied) || (lo_out && !hi_lo_shift)) begin
                // wraps mod word_slots when the tail sits in the next word
                lo_off <= lo_off + lo_remain[slot_off_width-1:0];
            end
        end
    end

    // one full word consumed per shift while the unit continues
    always_ff @(posedge clk) begin
        if (hi_lo_shift && !lo_satisfied) begin
            lo_remain_reg <= lo_remain - len_slots_width'(word_slots);
        end
    end

    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            shift_buf[word_slots +: word_slots] <= in_data;
        end
        if (hi_lo_shift) begin
            shift_buf[0 +: word_slots] <= shift_buf[word_slots +: word_slots];
        end
    end

    // register stage toward the assembler
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= lo_out && !lo_pad;
        end
        seg_data <= lo_seg;
        // back to bits
        seg_len  <= {lo_remain, {(offset_width-len_slots_width){1'b0}}};
    end

endmodule

/* hdl/unit_assembler.sv */
`timescale 1ns/1ps

module unit_assembler (
    input  logic                                      clk,
    input  logic                                      sync_rst_n,
    input  logic                                      seg_valid,
    input  trace_format_pkg::trace_word_u             seg_data,
    input  logic [trace_format_pkg::offset_width-1:0] seg_len,
    output logic [trace_format_pkg::unit_width-1:0]   unit_data,
    output logic                                      unit_wr_en
);
    import trace_format_pkg::*;
    import parser_ctrl_pkg::*;

    asm_state_e asm_state;
    asm_state_e asm_state_next;

    logic [unit_words-1:0][word_width-1:0] unit_buf;

    // words stored so far for the current unit
    logic [$clog2(unit_words+1)-1:0] word_cnt;
    logic [offset_width-1:0]         unit_len;
    logic [offset_width-1:0]         covered_len;
    logic                            seg_fits;

    // bits held once the arriving body segment is stored
    assign covered_len = offset_width'((word_cnt + 1'b1) * word_width);

    // a header segment that already carries the whole unit
    assign seg_fits = (seg_len <= offset_width'(word_width));

    always_comb begin
        case (asm_state)
            asm_wait_header: begin
                if (seg_valid) begin
                    asm_state_next = seg_fits ? asm_done : asm_wait_body;
                end else begin
                    asm_state_next = asm_wait_header;
                end
            end
            asm_wait_body: begin
                if (seg_valid && (unit_len <= covered_len)) begin
                    asm_state_next = asm_done;
                end else begin
                    asm_state_next = asm_wait_body;
                end
            end
            asm_done: begin
                // next header may follow right away
                if (seg_valid) begin
                    asm_state_next = seg_fits ? asm_done : asm_wait_body;
                end else begin
                    asm_state_next = asm_wait_header;
                end
            end
            default: asm_state_next = asm_wait_header;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= asm_wait_header;
            word_cnt  <= '0;
            unit_len  <= '0;
        end else begin
            asm_state <= asm_state_next;
            if (asm_state == asm_wait_body) begin
                word_cnt <= word_cnt + seg_valid;
            end else if (seg_valid) begin
                // a segment outside wait_body always opens a unit
                unit_len <= seg_len;
                word_cnt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seg_valid) begin
            if (asm_state == asm_wait_body) begin
                unit_buf[word_cnt[$clog2(unit_words)-1:0]] <= seg_data.raw;
            end else begin
                unit_buf[0] <= seg_data.raw;
            end
        end
    end

    // almost-full on the output is already applied at the input read
    assign unit_wr_en = (asm_state == asm_done);
    assign unit_data  = unit_buf;

endmodule

/* hdl/trace_parser_top.sv */
`timescale 1ns/1ps

module trace_parser_top (
    input  logic                                    clk,
    input  logic                                    sync_rst_n,
    input  logic [trace_format_pkg::word_width-1:0] in_data,
    input  logic                                    in_empty,
    output logic                                    in_rd_en,
    input  logic                                    out_almfull,
    output logic [trace_format_pkg::unit_width-1:0] unit_data,
    output logic                                    unit_wr_en
);
    import trace_format_pkg::*;

    // registered segment link
    logic                    seg_valid;
    trace_word_u             seg_data;
    logic [offset_width-1:0] seg_len;

    // input side, two-word buffer and segment extraction
    replay_shift_buffer u_shift_buffer (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .in_rd_en    (in_rd_en),
        .seg_valid   (seg_valid),
        .seg_data    (seg_data),
        .seg_len     (seg_len)
    );

    // output side, one full unit per write
    unit_assembler u_assembler (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .seg_valid  (seg_valid),
        .seg_data   (seg_data),
        .seg_len    (seg_len),
        .unit_data  (unit_data),
        .unit_wr_en (unit_wr_en)
    );

endmodule

/* tests/trace_parser_assertions.sv */
`timescale 1ns/1ps

module trace_parser_assertions (
    input logic                                    clk,
    input logic                                    sync_rst_n,
    input logic                                    in_empty,
    input logic                                    in_rd_en,
    input logic                                    out_almfull,
    input logic [trace_format_pkg::unit_width-1:0] unit_data,
    input logic                                    unit_wr_en
);
    import trace_format_pkg::*;

    // length field of the unit being written
    logic [offset_width-1:0] unit_len;

    // number of assertion failures so far
    int fail_count = 0;

    assign unit_len = unit_data[offset_width-1:0];

    // reads only from a non-empty FIFO and with room downstream
    read_guard: assert property (@(posedge clk) disable iff (!sync_rst_n)
        in_rd_en |-> (!in_empty && !out_almfull))
        else begin
            fail_count++;
            $error("in_rd_en high while in_empty or out_almfull is set");
        end

    // no write straight out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(sync_rst_n) |-> !unit_wr_en)
        else begin
            fail_count++;
            $error("unit_wr_en high in the first cycle after reset");
        end

    // byte aligned, at least the 16-bit minimum, at most one full unit
    len_legal: assert property (@(posedge clk) disable iff (!sync_rst_n)
        unit_wr_en |-> ((unit_len[2:0] == 3'b000) && (unit_len >= 16) && (unit_len <= 256)))
        else begin
            fail_count++;
            $error("unit written with an illegal length field %h", unit_len);
        end

endmodule

bind trace_parser_top trace_parser_assertions u_assertions (
    .clk         (clk),
    .sync_rst_n  (sync_rst_n),
    .in_empty    (in_empty),
    .in_rd_en    (in_rd_en),
    .out_almfull (out_almfull),
    .unit_data   (unit_data),
    .unit_wr_en  (unit_wr_en)
);

/* include/tb_util.svh */
`ifndef tb_util_svh
`define tb_util_svh

// 16-bit galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 16'hb400;
    end
    return next;
endfunction

// take n bits from the lfsr, one step per bit
function automatic logic [31:0] lfsr_bits(ref logic [15:0] state, input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value[i] = state[0];
        state = lfsr_step(state);
    end
    return value;
endfunction

// random payload with the length field written over the low 9 bits
function automatic logic [255:0] make_unit(ref logic [15:0] state, input int len_bits);
    logic [255:0] unit;
    unit = '0;
    for (int i = 0; i < len_bits; i++) begin
        unit[i] = state[0];
        state = lfsr_step(state);
    end
    unit[8:0] = len_bits[8:0];
    return unit;
endfunction

// bit_pos counts from the start of words, tail of the last word stays zero
function automatic void push_unit(ref logic [63:0] words[$], ref int bit_pos,
                                  input logic [255:0] unit, input int len_bits);
    int p;
    for (int i = 0; i < len_bits; i++) begin
        p = bit_pos + i;
        while (words.size() <= p / 64) begin
            words.push_back('0);
        end
        words[p / 64][p % 64] = unit[i];
    end
    bit_pos += len_bits;
endfunction

// closes the stream with the one extra word the parser needs
function automatic void push_padding(ref logic [63:0] words[$], ref int bit_pos);
    words.push_back('0);
    bit_pos = words.size() * 64;
endfunction

// head of the input fifo model, zero when empty
function automatic logic [63:0] fifo_head(ref logic [63:0] words[$]);
    return (words.size() > 0) ? words[0] : '0;
endfunction

task automatic check_value(input string name, input logic [255:0] got,
                           input logic [255:0] expected);
    if (got !== expected) begin
        $display("ERROR: %s got %h expected %h", name, got, expected);
        $display("Test failed");
        $fatal(1);
    end
endtask

`endif

/* tests/trace_parser_tb.sv */
`timescale 1ns/1ps

module trace_parser_tb;
    import trace_format_pkg::*;

    `include "tb_util.svh"

    logic                  clk = 1'b0;
    logic                  sync_rst_n;
    logic [word_width-1:0] in_data = '0;
    logic                  in_empty = 1'b1;
    logic                  in_rd_en;
    logic                  out_almfull;
    logic [unit_width-1:0] unit_data;
    logic                  unit_wr_en;

    // words waiting in the upstream FIFO model, head is on in_data
    logic [63:0]  in_q[$];
    // scoreboard, expected units in order with their lengths in bits
    logic [255:0] exp_units[$];
    int           exp_lens[$];
    logic [255:0] exp_unit;
    int           exp_len;
    trace_word_u  first_word;
    int           words_queued = 0;
    int           cycle_count = 0;
    logic [15:0]  lfsr_state = 16'd60;

    always #10 clk = ~clk;

    trace_parser_top uut (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_almfull (out_almfull),
        .unit_data   (unit_data),
        .unit_wr_en  (unit_wr_en)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // only the low len_bits of an emitted unit belong to it
    function automatic logic [255:0] unit_mask(input int len_bits);
        logic [255:0] mask;
        mask = '0;
        for (int i = 0; i < len_bits; i++) begin
            mask[i] = 1'b1;
        end
        return mask;
    endfunction

    // show-ahead FIFO, pop on a read edge then present the new head
    always @(posedge clk) begin
        if (in_rd_en && (in_q.size() > 0)) begin
            void'(in_q.pop_front());
        end
        in_empty <= (in_q.size() == 0);
        in_data  <= fifo_head(in_q);
    end

    // scoreboard, unit_wr_en is stable at the falling edge
    always @(negedge clk) begin
        if (sync_rst_n && unit_wr_en) begin
            if (exp_units.size() == 0) begin
                fail_run("unit_wr_en pulsed with no unit left to expect");
            end else begin
                exp_unit = exp_units.pop_front();
                exp_len  = exp_lens.pop_front();
                first_word.raw = unit_data[word_width-1:0];
                check_value("unit_data length field", first_word.hdr.len, exp_len);
                check_value("unit_data", unit_data & unit_mask(exp_len), exp_unit);
            end
        end
    end

    // assertion failures counted by the bound checker
    always @(negedge clk) begin
        if (uut.u_assertions.fail_count != 0) begin
            fail_run("a concurrent assertion on the DUT ports failed");
        end
    end

    // limit grows by 200 cycles for each queued word, one word of slack for reset
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 200 * (words_queued + 1)) begin
            fail_run("timeout, the parser stopped producing the expected units");
        end
    end

    // encode units back to back, expected copies go to the scoreboard
    task automatic build_stream(input int lens[$], ref logic [63:0] words[$]);
        logic [255:0] unit;
        int           bit_pos;
        bit_pos = 0;
        foreach (lens[i]) begin
            unit = make_unit(lfsr_state, lens[i]);
            exp_units.push_back(unit);
            exp_lens.push_back(lens[i]);
            push_unit(words, bit_pos, unit, lens[i]);
        end
        push_padding(words, bit_pos);
    endtask

    // queue changes at the falling edge, the FIFO model picks them up at the next rise
    task automatic load_words(ref logic [63:0] words[$]);
        @(negedge clk);
        foreach (words[i]) begin
            in_q.push_back(words[i]);
        end
        words_queued += words.size();
    endtask

    task automatic drain_units();
        while (exp_units.size() != 0) begin
            @(posedge clk);
        end
        // a stray write would land in this window
        repeat (20) @(posedge clk);
    endtask

    task automatic run_stream(input int lens[$]);
        logic [63:0] words[$];
        build_stream(lens, words);
        load_words(words);
        drain_units();
    endtask

    task automatic test_single_short();
        int lens[$];
        lens = {40};
        run_stream(lens);
    endtask

    // several of these cross one or two word boundaries
    task automatic test_straddle();
        int lens[$];
        lens = {48, 120, 72, 200, 16, 96, 136};
        run_stream(lens);
    endtask

    // 24-bit lead unit pushes the 256-bit unit to byte 3, spread over five words
    task automatic test_max_misaligned();
        int lens[$];
        lens = {24, 256, 56};
        run_stream(lens);
    endtask

    task automatic test_back_pressure();
        int          lens[$];
        logic [63:0] words[$];
        int          held;
        lens = {88, 176, 40};
        build_stream(lens, words);
        @(posedge clk);
        out_almfull <= 1'b1;
        load_words(words);
        held = in_q.size();
        repeat (30) begin
            @(negedge clk);
            check_value("in_rd_en", in_rd_en, 1'b0);
            check_value("input queue size", in_q.size(), held);
        end
        @(posedge clk);
        out_almfull <= 1'b0;
        drain_units();
    endtask

    // 2..32 slots of 8 bits each
    task automatic test_random();
        int lens[$];
        for (int i = 0; i < 40; i++) begin
            lens.push_back(8 * (2 + int'(lfsr_bits(lfsr_state, 5) % 31)));
        end
        run_stream(lens);
    endtask

    initial begin
        sync_rst_n  <= 1'b0;
        out_almfull <= 1'b0;
        repeat (5) @(posedge clk);
        sync_rst_n <= 1'b1;
        @(posedge clk);
        test_single_short();
        test_straddle();
        test_max_misaligned();
        test_back_pressure();
        test_random();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hdl/trace_format_pkg.sv
hdl/parser_ctrl_pkg.sv
hdl/replay_shift_buffer.sv
hdl/unit_assembler.sv
hdl/trace_parser_top.sv
tests/trace_parser_assertions.sv
tests/trace_parser_tb.sv

/* Makefile */
# Verilator simulation of the trace parser

VERILATOR ?= verilator
TOP       ?= trace_parser_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
